// ==== rtl/hdc_defs.svh ====
`ifndef HDC_DEFS_SVH
`define HDC_DEFS_SVH

// Sample geometry
`define FEATURE_COUNT 617
`define LEVEL_BITS 4
`define LEVEL_COUNT 16

// Hypervector width
`define HV_DIM 64

// Majority threshold, a dimension is set when the count is strictly above it
`define ENCODING_BIT_THR 308

// ID key rule: key = low bits of (dim * mult + add)
`define ID_KEY_MULT 157
`define ID_KEY_ADD 1

// Wide enough for a count of FEATURE_COUNT
`define COUNT_BITS 10

`endif

// ==== rtl/hdc_pkg.sv ====
`include "hdc_defs.svh"

package hdc_pkg;

    // One quantized feature level
    typedef logic [`LEVEL_BITS-1:0] level_t;

    // Feature index, also the buffer write pointer
    typedef logic [9:0] feat_idx_t;

    // Dimension index within a hypervector
    typedef logic [5:0] dim_idx_t;

    typedef logic [`HV_DIM-1:0] hv_t;

    // All bound bits of one dimension
    typedef logic [`FEATURE_COUNT-1:0] bundle_bits_t;

    // Encoder controller states
    typedef enum logic [1:0] {
        ST_LOAD,
        ST_SWEEP,
        ST_DRAIN,
        ST_EMIT
    } enc_state_t;

endpackage

// ==== rtl/feature_buffer.sv ====
`timescale 1ns/1ns
`include "hdc_defs.svh"

module feature_buffer (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  feat_valid,
    output logic                                  feat_ready,
    input  hdc_pkg::level_t                       feat_level,
    input  logic                                  buf_clear,
    output logic                                  buf_full,
    output logic [`FEATURE_COUNT*`LEVEL_BITS-1:0] levels
);

    hdc_pkg::feat_idx_t wr_ptr;
    hdc_pkg::level_t    level_mem [`FEATURE_COUNT];
    logic               wr_en;

    // Full once every feature slot has been written
    assign buf_full   = (wr_ptr == hdc_pkg::feat_idx_t'(`FEATURE_COUNT));
    assign feat_ready = !buf_full;
    assign wr_en      = feat_valid && feat_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (buf_clear) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Level storage in arrival order
    always_ff @(posedge clk) begin
        if (wr_en) begin
            level_mem[wr_ptr] <= feat_level;
        end
    end

    // Feature i sits in slice i of the flat level vector
    for (genvar i = 0; i < `FEATURE_COUNT; i++) begin : g_pack
        assign levels[i*`LEVEL_BITS +: `LEVEL_BITS] = level_mem[i];
    end

endmodule

// ==== rtl/item_memory.sv ====
`timescale 1ns/1ns
`include "hdc_defs.svh"

module item_memory (
    input  hdc_pkg::dim_idx_t                     dim_idx,
    input  logic [`FEATURE_COUNT*`LEVEL_BITS-1:0] levels,
    output hdc_pkg::bundle_bits_t                 bound_bits
);

    hdc_pkg::feat_idx_t dim_key;

    // Key for this dimension, truncated to the index width
    assign dim_key = hdc_pkg::feat_idx_t'(int'(dim_idx) * `ID_KEY_MULT + `ID_KEY_ADD);

    for (genvar i = 0; i < `FEATURE_COUNT; i++) begin : g_bind
        // IDs start at 1 so feature 0 is not all zeros
        localparam hdc_pkg::feat_idx_t FEAT_ID = hdc_pkg::feat_idx_t'(i + 1);

        hdc_pkg::level_t lvl;
        logic            id_bit;
        logic            level_bit;

        assign lvl = levels[i*`LEVEL_BITS +: `LEVEL_BITS];

        // Parity of the ID masked by the key
        assign id_bit = ^(FEAT_ID & dim_key);

        // Thermometer code, higher levels set more dimensions
        assign level_bit = (int'(dim_idx) * `LEVEL_COUNT) < (int'(lvl) * `HV_DIM);

        assign bound_bits[i] = id_bit ^ level_bit;
    end

endmodule

// ==== rtl/enc_bundler.sv ====
`timescale 1ns/1ns
`include "hdc_defs.svh"

module enc_bundler (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  bundling_features,
    input  hdc_pkg::bundle_bits_t bits_to_bundle,
    output logic                  thresholded_bit
);

    localparam int N_FEAT = `FEATURE_COUNT;
    localparam int N_PAIR = N_FEAT / 2;
    localparam int N_LVL0 = (N_FEAT + 1) / 2;
    localparam int CB     = `COUNT_BITS;

    // Node count of a tree level, odd nodes pass up unchanged
    function automatic int level_nodes(input int lvl);
        int n;
        n = N_LVL0;
        for (int k = 0; k < lvl; k++) begin
            n = (n + 1) / 2;
        end
        return n;
    endfunction

    function automatic int tree_depth();
        int n;
        int d;
        n = N_LVL0;
        d = 0;
        while (n > 1) begin
            n = (n + 1) / 2;
            d++;
        end
        return d;
    endfunction

    localparam int DEPTH = tree_depth();

    logic [1:0]    lvl0_q [N_LVL0];
    logic [CB-1:0] tree [DEPTH+1][N_LVL0];
    logic [CB-1:0] accumulated_sum;

    // First adder level, held while the sweep is idle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < N_LVL0; i++) begin
                lvl0_q[i] <= '0;
            end
        end else if (bundling_features) begin
            for (int i = 0; i < N_PAIR; i++) begin
                lvl0_q[i] <= 2'(bits_to_bundle[2*i]) + 2'(bits_to_bundle[2*i+1]);
            end
            if (N_FEAT % 2 == 1) begin
                lvl0_q[N_LVL0-1] <= 2'(bits_to_bundle[N_FEAT-1]);
            end
        end
    end

    for (genvar i = 0; i < N_LVL0; i++) begin : g_lvl0
        assign tree[0][i] = CB'(lvl0_q[i]);
    end

    // Remaining levels of the binary tree
    for (genvar l = 1; l <= DEPTH; l++) begin : g_level
        localparam int N_PREV = level_nodes(l - 1);
        for (genvar i = 0; i < N_PREV / 2; i++) begin : g_add
            assign tree[l][i] = tree[l-1][2*i] + tree[l-1][2*i+1];
        end
        // Odd leftover moves up a level
        if (N_PREV % 2 == 1) begin : g_carry
            assign tree[l][N_PREV/2] = tree[l-1][N_PREV-1];
        end
    end

    assign accumulated_sum = tree[DEPTH][0];
    assign thresholded_bit = (accumulated_sum > CB'(`ENCODING_BIT_THR));

endmodule

// ==== rtl/encoder_ctrl.sv ====
`timescale 1ns/1ns
`include "hdc_defs.svh"

module encoder_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              buf_full,
    output logic              buf_clear,
    output hdc_pkg::dim_idx_t dim_idx,
    output logic              bundle_en,
    input  logic              dim_bit,
    output logic              hv_valid,
    input  logic              hv_ready,
    output hdc_pkg::hv_t      hv
);

    hdc_pkg::enc_state_t state;
    hdc_pkg::dim_idx_t   dim_cnt;
    hdc_pkg::dim_idx_t   wr_pos;
    hdc_pkg::hv_t        hv_reg;
    logic                capture;
    logic                last_dim;

    assign last_dim = (dim_cnt == hdc_pkg::dim_idx_t'(`HV_DIM - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= hdc_pkg::ST_LOAD;
            dim_cnt <= '0;
        end else begin
            case (state)
                hdc_pkg::ST_LOAD: begin
                    dim_cnt <= '0;
                    if (buf_full) begin
                        state <= hdc_pkg::ST_SWEEP;
                    end
                end
                hdc_pkg::ST_SWEEP: begin
                    // Wraps to zero after the last dimension
                    dim_cnt <= dim_cnt + 1'b1;
                    if (last_dim) begin
                        state <= hdc_pkg::ST_DRAIN;
                    end
                end
                hdc_pkg::ST_DRAIN: begin
                    state <= hdc_pkg::ST_EMIT;
                end
                hdc_pkg::ST_EMIT: begin
                    if (hv_ready) begin
                        state <= hdc_pkg::ST_LOAD;
                    end
                end
                default: begin
                    state <= hdc_pkg::ST_LOAD;
                end
            endcase
        end
    end

    // The bundler answers one cycle after each index
    assign wr_pos  = dim_cnt - 1'b1;
    assign capture = ((state == hdc_pkg::ST_SWEEP) && (dim_cnt != '0))
                     || (state == hdc_pkg::ST_DRAIN);

    always_ff @(posedge clk) begin
        if (capture) begin
            hv_reg[wr_pos] <= dim_bit;
        end
    end

    assign dim_idx   = dim_cnt;
    assign bundle_en = (state == hdc_pkg::ST_SWEEP);
    assign hv_valid  = (state == hdc_pkg::ST_EMIT);
    assign hv        = hv_reg;

    // Empty the buffer on the output handshake
    assign buf_clear = (state == hdc_pkg::ST_EMIT) && hv_ready;

endmodule

// ==== rtl/hdc_encoder.sv ====
`timescale 1ns/1ns
`include "hdc_defs.svh"

module hdc_encoder (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            feat_valid,
    output logic            feat_ready,
    input  hdc_pkg::level_t feat_level,
    output logic            hv_valid,
    input  logic            hv_ready,
    output hdc_pkg::hv_t    hv
);

    logic [`FEATURE_COUNT*`LEVEL_BITS-1:0] levels;
    logic                                  buf_full;
    logic                                  buf_clear;
    hdc_pkg::dim_idx_t                     dim_idx;
    hdc_pkg::bundle_bits_t                 bound_bits;
    logic                                  bundle_en;
    logic                                  dim_bit;

    feature_buffer u_feature_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .feat_valid (feat_valid),
        .feat_ready (feat_ready),
        .feat_level (feat_level),
        .buf_clear  (buf_clear),
        .buf_full   (buf_full),
        .levels     (levels)
    );

    encoder_ctrl u_encoder_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .buf_full  (buf_full),
        .buf_clear (buf_clear),
        .dim_idx   (dim_idx),
        .bundle_en (bundle_en),
        .dim_bit   (dim_bit),
        .hv_valid  (hv_valid),
        .hv_ready  (hv_ready),
        .hv        (hv)
    );

    // Bound bits for the dimension being issued
    item_memory u_item_memory (
        .dim_idx    (dim_idx),
        .levels     (levels),
        .bound_bits (bound_bits)
    );

    enc_bundler u_enc_bundler (
        .clk               (clk),
        .rst_n             (rst_n),
        .bundling_features (bundle_en),
        .bits_to_bundle    (bound_bits),
        .thresholded_bit   (dim_bit)
    );

endmodule

// ==== test/clock_gen.sv ====
`timescale 1ns/1ns

module clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== test/tb_hdc_encoder.sv ====
`timescale 1ns/1ns
`include "hdc_defs.svh"

module tb_hdc_encoder;

    localparam int NUM_VECTORS = 12;
    localparam int CLK_NS      = 8;
    localparam int LV_W        = `FEATURE_COUNT * `LEVEL_BITS;
    // Edges from the last accepted feature to hv_valid
    localparam int LATENCY     = 66;

    logic            clk;
    logic            rst_n;
    logic            feat_valid;
    logic            feat_ready;
    hdc_pkg::level_t feat_level;
    logic            hv_valid;
    logic            hv_ready;
    hdc_pkg::hv_t    hv;

    // Expected hypervectors and test names, in send order
    hdc_pkg::hv_t exp_q [$];
    string        name_q [$];
    int           sent_cnt = 0;
    int           recv_cnt = 0;
    int           err_cnt = 0;
    int           hold_cycles = 0;
    bit           stall_mode;

    clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(2)) u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    hdc_encoder uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .feat_valid (feat_valid),
        .feat_ready (feat_ready),
        .feat_level (feat_level),
        .hv_valid   (hv_valid),
        .hv_ready   (hv_ready),
        .hv         (hv)
    );

    // Expected hypervector straight from the ID, level and majority rules
    function automatic hdc_pkg::hv_t ref_hv(input logic [LV_W-1:0] lv);
        hdc_pkg::hv_t result;
        int           key;
        int           count;
        int           q;
        bit           id_bit;
        bit           lvl_bit;
        result = '0;
        for (int d = 0; d < `HV_DIM; d++) begin
            key   = (d * `ID_KEY_MULT + `ID_KEY_ADD) % 1024;
            count = 0;
            for (int i = 0; i < `FEATURE_COUNT; i++) begin
                id_bit  = ($countones((i + 1) & key) % 2) == 1;
                q       = int'(lv[i*`LEVEL_BITS +: `LEVEL_BITS]);
                lvl_bit = (d * `LEVEL_COUNT) < (q * `HV_DIM);
                if (id_bit != lvl_bit) begin
                    count++;
                end
            end
            result[d] = (count > `ENCODING_BIT_THR);
        end
        return result;
    endfunction

    function automatic logic [LV_W-1:0] random_levels();
        logic [LV_W-1:0] lv;
        for (int i = 0; i < `FEATURE_COUNT; i++) begin
            lv[i*`LEVEL_BITS +: `LEVEL_BITS] = `LEVEL_BITS'($urandom_range(0, `LEVEL_COUNT - 1));
        end
        return lv;
    endfunction

    task automatic check_value(input string test_name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            err_cnt++;
            $display("Fail %s: expected %h actual %h", test_name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // One full sample, optionally with idle cycles between features
    task automatic send_sample(input string test_name, input logic [LV_W-1:0] lv,
                               input bit with_gaps);
        bit taken;
        int gap;
        exp_q.push_back(ref_hv(lv));
        name_q.push_back(test_name);
        for (int i = 0; i < `FEATURE_COUNT; i++) begin
            if (with_gaps && ($urandom_range(0, 3) == 0)) begin
                gap        = $urandom_range(1, 3);
                feat_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            feat_valid = 1'b1;
            feat_level = lv[i*`LEVEL_BITS +: `LEVEL_BITS];
            taken      = 1'b0;
            while (!taken) begin
                @(posedge clk);
                taken = feat_ready;
                @(negedge clk);
            end
        end
        feat_valid = 1'b0;
        sent_cnt++;
    endtask

    // Output ready, held low for a while once a stalled output is offered
    initial begin : ready_drive
        hv_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (stall_mode && (!hv_valid || (hold_cycles > 0))) begin
                hv_ready = 1'b0;
                if (hv_valid) begin
                    hold_cycles--;
                end
            end else begin
                hv_ready = 1'b1;
            end
        end
    end

    // Handshake monitor and comparison
    initial begin : monitor
        int           cyc;
        int           acc_cnt;
        int           acc_cyc;
        bit           prev_valid;
        bit           holding;
        bit           after_hs;
        hdc_pkg::hv_t held_hv;
        hdc_pkg::hv_t exp_hv;
        string        tname;
        cyc        = 0;
        acc_cnt    = 0;
        acc_cyc    = 0;
        prev_valid = 1'b0;
        holding    = 1'b0;
        after_hs   = 1'b0;
        forever begin
            @(posedge clk);
            cyc++;
            if (rst_n) begin
                if (after_hs) begin
                    check_value("feat_ready after handshake", 64'(1), 64'(feat_ready));
                    after_hs = 1'b0;
                end
                if (feat_valid && feat_ready) begin
                    acc_cnt++;
                    if (acc_cnt == `FEATURE_COUNT) begin
                        acc_cnt = 0;
                        acc_cyc = cyc;
                    end
                end
                if (holding) begin
                    check_value("hv_valid held", 64'(1), 64'(hv_valid));
                    check_value("hv held under back-pressure", held_hv, hv);
                end
                if (hv_valid) begin
                    check_value("feat_ready while hv_valid", 64'(0), 64'(feat_ready));
                    // A sample here shows the value set by the edge before
                    if (!prev_valid) begin
                        check_value("hv_valid latency", 64'(LATENCY), 64'(cyc - acc_cyc - 1));
                    end
                    if (hv_ready) begin
                        if (exp_q.size() == 0) begin
                            $display("Encoder delivered a hypervector that was never requested");
                            $display("=== FAIL ===");
                            $fatal(1, "Unexpected output");
                        end
                        exp_hv = exp_q.pop_front();
                        tname  = name_q.pop_front();
                        check_value(tname, exp_hv, hv);
                        recv_cnt++;
                        holding  = 1'b0;
                        after_hs = 1'b1;
                    end else begin
                        holding = 1'b1;
                        held_hv = hv;
                    end
                end
                prev_valid = hv_valid;
            end
        end
    end

    initial begin : watchdog
        #(NUM_VECTORS * 1000 * CLK_NS);
        $display("Watchdog expired, the encoder stopped producing hypervectors");
        $display("=== FAIL ===");
        $fatal(1, "Timeout");
    end

    initial begin : main
        void'($urandom(82));
        feat_valid = 1'b0;
        feat_level = '0;
        stall_mode = 1'b0;
        wait (rst_n === 1'b1);
        @(negedge clk);

        check_value("reset feat_ready", 64'(1), 64'(feat_ready));
        check_value("reset hv_valid", 64'(0), 64'(hv_valid));

        // ID majority alone, then the thermometer near its top
        send_sample("all levels 0", '0, 1'b0);
        send_sample("all levels 15", '1, 1'b0);

        for (int k = 0; k < 8; k++) begin
            send_sample($sformatf("random vector %0d", k), random_levels(), 1'b0);
        end

        send_sample("gapped load", random_levels(), 1'b1);

        // Stall only the last sample, once the earlier outputs are taken
        wait (recv_cnt == sent_cnt);
        hold_cycles = $urandom_range(3, 20);
        stall_mode  = 1'b1;
        @(negedge clk);
        send_sample("back-pressure", random_levels(), 1'b0);

        wait (recv_cnt == sent_cnt);
        repeat (2) @(negedge clk);
        if (err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/hdc_pkg.sv
rtl/feature_buffer.sv
rtl/item_memory.sv
rtl/enc_bundler.sv
rtl/encoder_ctrl.sv
rtl/hdc_encoder.sv
test/clock_gen.sv
test/tb_hdc_encoder.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the encoder testbench with Verilator from the project root

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_hdc_encoder -o sim_hdc \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_hdc > sim.log 2>&1
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
